// ==== logic/crd_store.sv ====
module crd_store #(
    parameter int IDX_WIDTH = fps_ctrl_pkg::idx_width_dflt
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    wr_en,
    input  logic [IDX_WIDTH-1:0]                    wr_addr,
    input  logic [fps_geom_pkg::crd_word_width-1:0] wr_data,
    input  logic                                    rd_en,
    input  logic [IDX_WIDTH-1:0]                    rd_addr,
    output logic [fps_geom_pkg::crd_word_width-1:0] rd_data
);

    localparam int depth = 2 ** IDX_WIDTH;

    // ====================
    // Point memory
    // ====================

    // One word per point, flat layout
    logic [fps_geom_pkg::crd_word_width-1:0] mem [depth];

    // Host write port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read, data one cycle after rd_en
    // Output holds between reads
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

    // Host loads points only while the engine is idle
    a_no_wr_rd: assert property (@(posedge clk) disable iff (!rst_n) !(wr_en && rd_en))
        else $error("point write during engine read");

endmodule

// ==== logic/dist_store.sv ====
module dist_store #(
    parameter int IDX_WIDTH = fps_ctrl_pkg::idx_width_dflt
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                dist_clr,
    input  logic                                rd_en,
    input  logic [IDX_WIDTH-1:0]                rd_addr,
    output logic [fps_geom_pkg::dist_width-1:0] rd_dist,
    input  logic                                wr_en,
    input  logic [IDX_WIDTH-1:0]                wr_addr,
    input  logic [fps_geom_pkg::dist_width-1:0] wr_val
);

    localparam int depth = 2 ** IDX_WIDTH;

    // ====================
    // Running minimums
    // ====================

    logic [fps_geom_pkg::dist_width-1:0] mem [depth];
    // Entry holds a real minimum of this run
    logic [depth-1:0]                    vld;

    // Clear wipes every entry in one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld <= '0;
        end else if (dist_clr) begin
            vld <= '0;
        end else if (wr_en) begin
            vld[wr_addr] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_val;
        end
    end

    // Invalid entry reads as the largest distance
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_dist <= vld[rd_addr] ? mem[rd_addr] : '1;
        end
    end

    // Minimum only ever shrinks within a run
    a_min_only: assert property (@(posedge clk) disable iff (!rst_n)
        (wr_en && vld[wr_addr]) |-> (wr_val <= mem[wr_addr]))
        else $error("running minimum raised");

endmodule

// ==== logic/dist_unit.sv ====
module dist_unit #(
    parameter int IDX_WIDTH = fps_ctrl_pkg::idx_width_dflt
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    rd_en,
    input  logic [IDX_WIDTH-1:0]                    rd_addr,
    input  logic                                    ctr_load,
    input  logic [fps_geom_pkg::crd_word_width-1:0] crd_data,
    input  logic [fps_geom_pkg::dist_width-1:0]     old_dist,
    output logic                                    dist_wr_en,
    output logic [IDX_WIDTH-1:0]                    dist_wr_addr,
    output logic [fps_geom_pkg::dist_width-1:0]     dist_wr_val,
    output logic [IDX_WIDTH-1:0]                    best_idx
);

    localparam int sq_width = 2 * fps_geom_pkg::crd_width;

    // Squared difference of one axis
    function automatic logic [sq_width-1:0] sq_diff(
        input logic [fps_geom_pkg::crd_width-1:0] a,
        input logic [fps_geom_pkg::crd_width-1:0] b
    );
        logic [sq_width-1:0] d;
        d = (a > b) ? sq_width'(a - b) : sq_width'(b - a);
        return d * d;
    endfunction

    // ====================
    // Stage 1
    // ====================

    // Tags that travel beside the store read
    logic                 s1_vld;
    logic                 s1_ctr;
    logic [IDX_WIDTH-1:0] s1_idx;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_vld <= 1'b0;
            s1_ctr <= 1'b0;
        end else begin
            s1_vld <= rd_en && !ctr_load;
            s1_ctr <= rd_en && ctr_load;
        end
    end

    always_ff @(posedge clk) begin
        s1_idx <= rd_addr;
    end

    // ====================
    // Stage 2
    // ====================

    fps_geom_pkg::crd_word_u    pt_w;
    fps_geom_pkg::crd_word_u    ctr_w;
    logic [fps_geom_pkg::dist_width-1:0] new_dist;
    logic [fps_geom_pkg::dist_width-1:0] new_min;
    logic [fps_geom_pkg::dist_width-1:0] best_dist;

    // Store word decoded into axes
    assign pt_w.flat = crd_data;

    assign new_dist = fps_geom_pkg::dist_width'(sq_diff(pt_w.axes.x, ctr_w.axes.x))
                    + fps_geom_pkg::dist_width'(sq_diff(pt_w.axes.y, ctr_w.axes.y))
                    + fps_geom_pkg::dist_width'(sq_diff(pt_w.axes.z, ctr_w.axes.z));
    assign new_min  = (new_dist < old_dist) ? new_dist : old_dist;

    // Center coordinates for the coming round
    always_ff @(posedge clk) begin
        if (s1_ctr) begin
            ctr_w <= pt_w;
        end
    end

    // Write-back lands two cycles after the read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dist_wr_en <= 1'b0;
        end else begin
            dist_wr_en <= s1_vld;
        end
    end

    always_ff @(posedge clk) begin
        dist_wr_addr <= s1_idx;
        dist_wr_val  <= new_min;
    end

    // Strictly greater arg-max keeps the lowest index on ties
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            best_dist <= '0;
            best_idx  <= '0;
        end else if (s1_ctr) begin
            best_dist <= '0;
            best_idx  <= '0;
        end else if (s1_vld && (new_min > best_dist)) begin
            best_dist <= new_min;
            best_idx  <= s1_idx;
        end
    end

endmodule

// ==== logic/fps_ctrl.sv ====
module fps_ctrl #(
    parameter int IDX_WIDTH = fps_ctrl_pkg::idx_width_dflt
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  logic [IDX_WIDTH-1:0] cfg_last_pt,
    input  logic [IDX_WIDTH-1:0] cfg_last_sel,
    input  logic [IDX_WIDTH-1:0] best_idx,
    output logic                 busy,
    output logic                 rd_en,
    output logic [IDX_WIDTH-1:0] rd_addr,
    output logic                 ctr_load,
    output logic                 dist_clr,
    output logic                 sel_vld,
    output logic [IDX_WIDTH-1:0] sel_idx,
    output logic                 done
);

    localparam int drain_w = $clog2(fps_ctrl_pkg::drain_cycles + 1);

    fps_ctrl_pkg::fps_state_e state;
    fps_ctrl_pkg::fps_state_e state_nxt;

    // Sampled configuration
    logic [IDX_WIDTH-1:0] last_pt;
    logic [IDX_WIDTH-1:0] last_sel;
    // Round counters
    logic [IDX_WIDTH-1:0] loop_cnt;
    logic [drain_w-1:0]   drain_cnt;
    logic [IDX_WIDTH-1:0] sel_cnt;
    // Current center
    logic [IDX_WIDTH-1:0] ctr_idx;

    logic start_ok;
    logic loop_last;
    logic drain_last;
    logic sel_last;

    assign start_ok   = start && (state == fps_ctrl_pkg::st_idle);
    assign loop_last  = (loop_cnt == last_pt);
    assign drain_last = (drain_cnt == drain_w'(fps_ctrl_pkg::drain_cycles - 1));
    assign sel_last   = (sel_cnt == last_sel);

    // ====================
    // FSM
    // ====================

    always_comb begin
        state_nxt = state;
        case (state)
            fps_ctrl_pkg::st_idle:   if (start_ok) state_nxt = fps_ctrl_pkg::st_center;
            // Last selection skips the loop
            fps_ctrl_pkg::st_center: state_nxt = sel_last ? fps_ctrl_pkg::st_done
                                                          : fps_ctrl_pkg::st_loop;
            fps_ctrl_pkg::st_loop:   if (loop_last) state_nxt = fps_ctrl_pkg::st_drain;
            fps_ctrl_pkg::st_drain:  if (drain_last) state_nxt = fps_ctrl_pkg::st_center;
            default:                 state_nxt = fps_ctrl_pkg::st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= fps_ctrl_pkg::st_idle;
            last_pt   <= '0;
            last_sel  <= '0;
            loop_cnt  <= '0;
            drain_cnt <= '0;
            sel_cnt   <= '0;
            ctr_idx   <= '0;
        end else begin
            state <= state_nxt;
            // New run, point 0 is always the first center
            if (start_ok) begin
                last_pt  <= cfg_last_pt;
                last_sel <= cfg_last_sel;
                sel_cnt  <= '0;
                ctr_idx  <= '0;
            end
            case (state)
                fps_ctrl_pkg::st_center: begin
                    loop_cnt <= '0;
                    sel_cnt  <= sel_cnt + 1'b1;
                end
                fps_ctrl_pkg::st_loop: begin
                    loop_cnt  <= loop_cnt + 1'b1;
                    drain_cnt <= '0;
                end
                fps_ctrl_pkg::st_drain: begin
                    drain_cnt <= drain_cnt + 1'b1;
                    // Pipeline empty, arg-max is final
                    if (drain_last) ctr_idx <= best_idx;
                end
                default: ;
            endcase
        end
    end

    // ====================
    // Outputs
    // ====================

    assign busy     = (state != fps_ctrl_pkg::st_idle);
    assign ctr_load = (state == fps_ctrl_pkg::st_center);
    assign rd_en    = ctr_load || (state == fps_ctrl_pkg::st_loop);
    assign rd_addr  = ctr_load ? ctr_idx : loop_cnt;
    // Every center is reported as it is fetched
    assign sel_vld  = ctr_load;
    assign sel_idx  = ctr_idx;
    assign done     = (state == fps_ctrl_pkg::st_done);
    // Old minimums go away with the start pulse
    assign dist_clr = start_ok;

    // Host must wait for idle
    a_start_idle: assert property (@(posedge clk) disable iff (!rst_n) start |-> !busy)
        else $error("start seen while busy");

    // Loop stays inside the sampled cloud
    a_loop_addr: assert property (@(posedge clk) disable iff (!rst_n)
        (state == fps_ctrl_pkg::st_loop) |-> (rd_addr <= last_pt))
        else $error("loop address beyond last point");

endmodule

// ==== logic/fps_ctrl_pkg.sv ====
package fps_ctrl_pkg;

    // ====================
    // Control settings
    // ====================

    // 16 points by default
    localparam int idx_width_dflt = 4;

    // Depth of the distance pipeline
    localparam int drain_cycles = 2;

    // Round sequencer states
    typedef enum logic [2:0] {
        st_idle,
        st_center,
        st_loop,
        st_drain,
        st_done
    } fps_state_e;

endpackage

// ==== logic/fps_geom_pkg.sv ====
package fps_geom_pkg;

    // ====================
    // Point geometry
    // ====================

    // Bits per axis, unsigned
    localparam int crd_width = 8;
    // Axes per point
    localparam int crd_dim = 3;
    // One point as stored in memory
    localparam int crd_word_width = crd_width * crd_dim;
    // Three squared differences need two extra bits
    localparam int dist_width = 2 * crd_width + 2;

    // Axis view, x in the low bits
    typedef struct packed {
        logic [crd_width-1:0] z;
        logic [crd_width-1:0] y;
        logic [crd_width-1:0] x;
    } crd_axes_s;

    // Memory word or axes, same bits
    typedef union packed {
        logic [crd_word_width-1:0] flat;
        crd_axes_s                 axes;
    } crd_word_u;

endpackage

// ==== logic/fps_top.sv ====
module fps_top #(
    parameter int IDX_WIDTH = fps_ctrl_pkg::idx_width_dflt
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    pt_wr,
    input  logic [IDX_WIDTH-1:0]                    pt_addr,
    input  logic [fps_geom_pkg::crd_word_width-1:0] pt_data,
    input  logic                                    start,
    input  logic [IDX_WIDTH-1:0]                    cfg_last_pt,
    input  logic [IDX_WIDTH-1:0]                    cfg_last_sel,
    output logic                                    busy,
    output logic                                    sel_vld,
    output logic [IDX_WIDTH-1:0]                    sel_idx,
    output logic                                    done
);

    // Shared read bus to both stores and the pipeline
    logic                                    rd_en;
    logic [IDX_WIDTH-1:0]                    rd_addr;
    logic                                    ctr_load;
    logic                                    dist_clr;
    // Store outputs
    logic [fps_geom_pkg::crd_word_width-1:0] crd_rd_data;
    logic [fps_geom_pkg::dist_width-1:0]     rd_dist;
    // Write-back and arg-max
    logic                                    dist_wr_en;
    logic [IDX_WIDTH-1:0]                    dist_wr_addr;
    logic [fps_geom_pkg::dist_width-1:0]     dist_wr_val;
    logic [IDX_WIDTH-1:0]                    best_idx;

    // ====================
    // Sequencer
    // ====================

    fps_ctrl #(.IDX_WIDTH(IDX_WIDTH)) fps_ctrl_i (
        .clk, .rst_n, .start, .cfg_last_pt, .cfg_last_sel, .best_idx,
        .busy, .rd_en, .rd_addr, .ctr_load, .dist_clr, .sel_vld, .sel_idx, .done
    );

    // ====================
    // Stores and pipeline
    // ====================

    crd_store #(.IDX_WIDTH(IDX_WIDTH)) crd_store_i (
        .clk, .rst_n, .wr_en(pt_wr), .wr_addr(pt_addr), .wr_data(pt_data),
        .rd_en, .rd_addr, .rd_data(crd_rd_data)
    );

    dist_store #(.IDX_WIDTH(IDX_WIDTH)) dist_store_i (
        .clk, .rst_n, .dist_clr, .rd_en, .rd_addr, .rd_dist,
        .wr_en(dist_wr_en), .wr_addr(dist_wr_addr), .wr_val(dist_wr_val)
    );

    dist_unit #(.IDX_WIDTH(IDX_WIDTH)) dist_unit_i (
        .clk, .rst_n, .rd_en, .rd_addr, .ctr_load,
        .crd_data(crd_rd_data), .old_dist(rd_dist),
        .dist_wr_en, .dist_wr_addr, .dist_wr_val, .best_idx
    );

endmodule

// ==== sim.f ====
logic/fps_geom_pkg.sv
logic/fps_ctrl_pkg.sv
logic/fps_ctrl.sv
logic/crd_store.sv
logic/dist_store.sv
logic/dist_unit.sv
logic/fps_top.sv
verif/fps_tb.sv

// ==== verif/fps_tb.sv ====
module fps_tb;

    localparam int idx_w      = fps_ctrl_pkg::idx_width_dflt;
    localparam int n_pts      = 2 ** idx_w;
    localparam int clk_period = 20;
    localparam int n_runs     = 5;

    logic                                    clk;
    logic                                    rst_n;
    logic                                    pt_wr;
    logic [idx_w-1:0]                        pt_addr;
    logic [fps_geom_pkg::crd_word_width-1:0] pt_data;
    logic                                    start;
    logic [idx_w-1:0]                        cfg_last_pt;
    logic [idx_w-1:0]                        cfg_last_sel;
    logic                                    busy;
    logic                                    sel_vld;
    logic [idx_w-1:0]                        sel_idx;
    logic                                    done;

    // Run table of last point, last selection, reload and duplicate period
    int run_pt   [n_runs] = '{15, 15, 15, 9, 11};
    int run_sl   [n_runs] = '{5, 0, 15, 6, 11};
    int run_load [n_runs] = '{1, 0, 0, 1, 1};
    int run_dup  [n_runs] = '{0, 0, 0, 0, 3};

    // Model copy of the cloud and expected selections
    fps_geom_pkg::crd_word_u pts [n_pts];
    logic [idx_w-1:0]        exp_sel [n_pts];
    logic [idx_w-1:0]        exp_idx;
    logic [7:0]              lfsr;

    // Run tracking beside the DUT
    logic                    run_on;
    logic [idx_w:0]          sel_cnt;
    logic [idx_w-1:0]        run_last_sel;

    fps_top #(.IDX_WIDTH(idx_w)) fps_top_i (
        .clk, .rst_n, .pt_wr, .pt_addr, .pt_data, .start, .cfg_last_pt, .cfg_last_sel,
        .busy, .sel_vld, .sel_idx, .done
    );

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    // ====================
    // Failure paths
    // ====================

    task automatic abort_run();
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string sig, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("error: %s expected %h actual %h", sig, exp, act);
        abort_run();
    endtask

    // ====================
    // Stimulus helpers
    // ====================

    // Taps x^8 + x^6 + x^5 + x^4 + 1 with one output bit per step
    function automatic logic next_bit();
        logic fb;
        logic b;
        b    = lfsr[7];
        fb   = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];
        lfsr = {lfsr[6:0], fb};
        return b;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], next_bit()};
        end
        return v;
    endfunction

    function automatic int sq_dist(input fps_geom_pkg::crd_word_u a,
                                   input fps_geom_pkg::crd_word_u b);
        int dx;
        int dy;
        int dz;
        dx = int'(a.axes.x) - int'(b.axes.x);
        dy = int'(a.axes.y) - int'(b.axes.y);
        dz = int'(a.axes.z) - int'(b.axes.z);
        return dx * dx + dy * dy + dz * dz;
    endfunction

    // Fill the whole store with later points repeating earlier ones if dup is set
    task automatic load_points(input int dup);
        for (int i = 0; i < n_pts; i++) begin
            @(posedge clk);
            #2;
            if (dup != 0 && i >= dup) begin
                pts[i] = pts[i % dup];
            end else begin
                pts[i].flat = fps_geom_pkg::crd_word_width'(
                    rand_bits(fps_geom_pkg::crd_word_width));
            end
            pt_wr   = 1'b1;
            pt_addr = idx_w'(i);
            pt_data = pts[i].flat;
        end
        @(posedge clk);
        #2;
        pt_wr = 1'b0;
    endtask

    // Farthest point rule where ties keep the lowest index
    task automatic compute_model(input int last_pt, input int last_sel);
        int min_d [n_pts];
        int ctr;
        int best;
        int bidx;
        int d;
        for (int i = 0; i < n_pts; i++) begin
            min_d[i] = 32'h7fff_ffff;
        end
        exp_sel[0] = '0;
        ctr = 0;
        for (int k = 1; k <= last_sel; k++) begin
            best = 0;
            bidx = 0;
            for (int i = 0; i <= last_pt; i++) begin
                d = sq_dist(pts[i], pts[ctr]);
                if (d < min_d[i]) min_d[i] = d;
                if (min_d[i] > best) begin
                    best = min_d[i];
                    bidx = i;
                end
            end
            exp_sel[k] = idx_w'(bidx);
            ctr = bidx;
        end
    endtask

    task automatic run_fps(input int last_pt, input int last_sel);
        compute_model(last_pt, last_sel);
        @(posedge clk);
        #2;
        start        = 1'b1;
        cfg_last_pt  = idx_w'(last_pt);
        cfg_last_sel = idx_w'(last_sel);
        @(posedge clk);
        #2;
        start = 1'b0;
        // Done ends the run since latency is variable
        while (!done) begin
            @(posedge clk);
            #2;
        end
    endtask

    // ====================
    // Run tracking
    // ====================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_on       <= 1'b0;
            sel_cnt      <= '0;
            run_last_sel <= '0;
        end else begin
            if (start) begin
                run_on       <= 1'b1;
                sel_cnt      <= '0;
                run_last_sel <= cfg_last_sel;
            end else begin
                if (done) run_on <= 1'b0;
                if (sel_vld) sel_cnt <= sel_cnt + 1'b1;
            end
        end
    end

    assign exp_idx = exp_sel[sel_cnt[idx_w-1:0]];

    // Quiet outside a run
    a_idle_busy: assert property (@(posedge clk) disable iff (!rst_n) !run_on |-> !busy)
        else report_mismatch("busy", 0, $sampled(busy));
    a_idle_sel: assert property (@(posedge clk) disable iff (!rst_n) !run_on |-> !sel_vld)
        else report_mismatch("sel_vld", 0, $sampled(sel_vld));
    a_idle_done: assert property (@(posedge clk) disable iff (!rst_n) !run_on |-> !done)
        else report_mismatch("done", 0, $sampled(done));

    // Busy from the cycle after start through done
    a_run_busy: assert property (@(posedge clk) disable iff (!rst_n) run_on |-> busy)
        else report_mismatch("busy", 1, $sampled(busy));

    a_first_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (sel_vld && sel_cnt == '0) |-> (sel_idx == '0))
        else report_mismatch("sel_idx", 0, $sampled(sel_idx));

    a_sel_model: assert property (@(posedge clk) disable iff (!rst_n)
        sel_vld |-> (sel_idx == exp_idx))
        else report_mismatch("sel_idx", $sampled(exp_idx), $sampled(sel_idx));

    // No extra selections and the full count by done
    a_sel_extra: assert property (@(posedge clk) disable iff (!rst_n)
        sel_vld |-> (sel_cnt <= {1'b0, run_last_sel}))
        else report_mismatch("sel_vld count", $sampled(run_last_sel), $sampled(sel_cnt));
    a_sel_count: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> (sel_cnt == {1'b0, run_last_sel} + 1'b1))
        else report_mismatch("sel_vld count", $sampled(run_last_sel) + 1, $sampled(sel_cnt));

    // ====================
    // Sequence and watchdog
    // ====================

    initial begin
        int budget;
        budget = 10 + 3 * (n_pts + 2);
        for (int r = 0; r < n_runs; r++) begin
            budget += (run_sl[r] + 1) * (run_pt[r] + 6) + 50;
        end
        #(budget * clk_period);
        $display("timeout: done never arrived within %0d cycles", budget);
        abort_run();
    end

    initial begin
        rst_n        = 1'b0;
        pt_wr        = 1'b0;
        pt_addr      = '0;
        pt_data      = '0;
        start        = 1'b0;
        cfg_last_pt  = '0;
        cfg_last_sel = '0;
        lfsr         = 8'd97;
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;
        // Runs cover a random cloud, one selection, all points, a reload and duplicates
        for (int r = 0; r < n_runs; r++) begin
            if (run_load[r] != 0) load_points(run_dup[r]);
            run_fps(run_pt[r], run_sl[r]);
        end
        @(posedge clk);
        #2;
        $display("Verification passed");
        $finish;
    end

endmodule
